// File: include/qsnd_defines.svh
/*
  register map and tuning constants for the sound board glue
  include wherever an offset, the miss counter width or the audio shift is needed
*/
`ifndef QSND_DEFINES_SVH
`define QSND_DEFINES_SVH

// host register offsets, 3-bit Wishbone address
`define QSND_REG_DATA_HI 3'd0 // data word, upper byte
`define QSND_REG_DATA_LO 3'd1 // data word, lower byte
`define QSND_REG_ADDR    3'd2 // address byte, writing it loads the mailbox
`define QSND_REG_CTRL    3'd3 // run bit and ROM bank
`define QSND_REG_STATUS  3'd7 // read-only status byte

// DSP clock enable
`define QSND_MISS_W      5    // stalled phases that can be made up, saturates at 31
`define QSND_CEN_PHASES  3    // one DSP enable slot every third clk48 cycle

// DSP serial words are scaled up before they leave the board
`define QSND_AUDIO_SHIFT 2

`endif

// File: verilog/qsnd_pkg.sv
/*
  common types for the sound board glue
  modules name these in their port lists and import the package in their bodies
*/
`default_nettype none

package qsnd_pkg;

    typedef logic [7:0]         host_byte_t; // host data bus
    typedef logic [3:0]         bank_t;      // sample ROM bank
    typedef logic [15:0]        dsp_word_t;  // DSP parallel and address buses
    typedef logic [22:0]        qsnd_addr_t; // sample ROM byte address, 8 MB
    typedef logic signed [15:0] audio_t;

    // Wishbone slave handshake
    typedef enum logic [0:0] {
        WB_IDLE, // waiting for cyc and stb
        WB_ACK   // ack high for this one cycle
    } wb_state_t;

endpackage

`default_nettype wire

// File: verilog/qsnd_host_regs.sv
/*
  Wishbone classic slave for the host CPU
  holds ROM bank, DSP run bit and the three mailbox bytes, returns the status byte
  writes land and ack rises on the same clock edge
*/
`timescale 1ns/10ps
`default_nettype none

`include "qsnd_defines.svh"

module qsnd_host_regs (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  qsnd_pkg::host_byte_t wb_dat_w,
    output qsnd_pkg::host_byte_t wb_dat_r,
    output logic                 wb_ack,
    input  logic                 dsp_rdy_n,
    output qsnd_pkg::bank_t      bank,
    output logic                 dsp_rst,
    output qsnd_pkg::dsp_word_t  mail_data,
    output qsnd_pkg::host_byte_t mail_addr,
    output logic                 mail_load
);

    import qsnd_pkg::*;

    wb_state_t  state;
    logic       wb_req;
    logic       wr_en;
    logic       rd_en;
    host_byte_t rd_mux;

    assign wb_req = wb_cyc & wb_stb;
    assign wb_ack = (state == WB_ACK);

    // accept only once per request, the ack cycle itself is ignored
    assign wr_en = wb_req & wb_we & (state == WB_IDLE);
    assign rd_en = wb_req & ~wb_we & (state == WB_IDLE);

    always_comb begin
        if (wb_adr == `QSND_REG_STATUS)
            rd_mux = {dsp_rdy_n, 3'b111, bank};
        else
            rd_mux = 8'hff; // unmapped and write-only offsets
    end

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            state     <= WB_IDLE;
            bank      <= '0;
            dsp_rst   <= 1'b1; // DSP held until the host sets run
            mail_load <= 1'b0;
        end else begin
            mail_load <= 1'b0;
            case (state)
                WB_IDLE: if (wb_req) state <= WB_ACK;
                WB_ACK:  state <= WB_IDLE;
                default: state <= WB_IDLE;
            endcase
            if (wr_en && wb_adr == `QSND_REG_CTRL) begin
                bank    <= wb_dat_w[3:0];
                dsp_rst <= ~wb_dat_w[7];
            end
            // address byte is written last and starts the transfer
            if (wr_en && wb_adr == `QSND_REG_ADDR)
                mail_load <= 1'b1;
        end
    end

    always_ff @(posedge clk48) begin
        if (wr_en) begin
            case (wb_adr)
                `QSND_REG_DATA_HI: mail_data[15:8] <= wb_dat_w;
                `QSND_REG_DATA_LO: mail_data[7:0]  <= wb_dat_w;
                `QSND_REG_ADDR:    mail_addr       <= wb_dat_w;
                default: ;
            endcase
        end
        if (rd_en)
            wb_dat_r <= rd_mux; // valid with ack
    end

endmodule

`default_nettype wire

// File: verilog/qsnd_mailbox.sv
/*
  hands the host mailbox to the DSP parallel input
  address byte first, then the data word, stepped by the DSP input strobe
*/
`timescale 1ns/10ps
`default_nettype none

module qsnd_mailbox (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 mail_load,
    input  qsnd_pkg::dsp_word_t  mail_data,
    input  qsnd_pkg::host_byte_t mail_addr,
    input  logic                 dsp_pids_n,
    input  logic                 dsp_iack,
    output logic                 dsp_irq,
    output logic                 dsp_rdy_n,
    output qsnd_pkg::dsp_word_t  dsp_pbus_in
);

    import qsnd_pkg::*;

    dsp_word_t  snap_data; // copies, so the host can refill the mailbox early
    host_byte_t snap_addr;
    logic [1:0] word_sel;
    logic       last_pids_n;
    logic       pids_rise;

    assign pids_rise = dsp_pids_n & ~last_pids_n; // end of a DSP read
    assign dsp_rdy_n = ~(dsp_irq | dsp_iack);

    // upper select bit marks the address phase
    assign dsp_pbus_in = word_sel[1] ? {8'd0, snap_addr} : snap_data;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            dsp_irq     <= 1'b0;
            word_sel    <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (mail_load) begin
                dsp_irq  <= 1'b1;
                word_sel <= 2'b11;
            end else if (pids_rise) begin
                dsp_irq  <= 1'b0;
                word_sel <= word_sel >> 1; // move on to the data word
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (mail_load) begin
            snap_data <= mail_data;
            snap_addr <= mail_addr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/qsnd_dsp_cen.sv
/*
  DSP clock enable, one slot every third clk48 cycle
  slots lost while the sample ROM is busy are counted and given back
  in the free cycles between slots once the ROM is ready
*/
`timescale 1ns/10ps
`default_nettype none

`include "qsnd_defines.svh"

module qsnd_dsp_cen (
    input  logic clk48,
    input  logic rst,
    input  logic qsnd_ok,
    input  logic dsp_ext_rq,
    output logic cen_dsp
);

    localparam logic [`QSND_CEN_PHASES-1:0] RING_INIT = 1;

    logic [`QSND_CEN_PHASES-1:0] ring;
    logic [`QSND_MISS_W-1:0]     miss;
    logic                        phase;
    logic                        rom_rdy;

    assign phase   = ring[`QSND_CEN_PHASES-1];
    assign rom_rdy = qsnd_ok | ~dsp_ext_rq; // no ROM access is as good as data ready

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            ring    <= RING_INIT;
            miss    <= '0;
            cen_dsp <= 1'b1;
        end else begin
            ring <= {ring[`QSND_CEN_PHASES-2:0], ring[`QSND_CEN_PHASES-1]};
            if (phase) begin
                if (rom_rdy) begin
                    cen_dsp <= 1'b1;
                end else begin
                    cen_dsp <= 1'b0;
                    if (~&miss)
                        miss <= miss + 1'b1; // saturating
                end
            end else if (miss != '0 && rom_rdy) begin
                cen_dsp <= 1'b1; // make-up cycle
                miss    <= miss - 1'b1;
            end else begin
                cen_dsp <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/qsnd_rom_addr.sv
/*
  sample ROM address built from two DSP writes
  low 16 bits come over the parallel port, the upper bits from the address bus
*/
`timescale 1ns/10ps
`default_nettype none

module qsnd_rom_addr (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 dsp_pods_n,
    input  logic                 dsp_cen_cko,
    input  qsnd_pkg::dsp_word_t  dsp_pbus_out,
    input  qsnd_pkg::dsp_word_t  dsp_ab,
    output qsnd_pkg::qsnd_addr_t qsnd_addr
);

    logic last_pods_n;
    logic pods_rise;
    logic bank_hit;

    assign pods_rise = dsp_pods_n & ~last_pods_n;
    assign bank_hit  = dsp_cen_cko & dsp_ab[15]; // external memory cycle

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            last_pods_n <= 1'b1;
            qsnd_addr   <= '0;
        end else begin
            last_pods_n <= dsp_pods_n;
            if (pods_rise)
                qsnd_addr[15:0] <= dsp_pbus_out;
            if (bank_hit)
                qsnd_addr[22:16] <= dsp_ab[6:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/qsnd_audio_latch.sv
/*
  stereo capture of the DSP serial words
  taken from the parallel copy, the serial line itself is not decoded
*/
`timescale 1ns/10ps
`default_nettype none

`include "qsnd_defines.svh"

module qsnd_audio_latch (
    input  logic                clk48,
    input  logic                rst,
    input  logic                dsp_sadd,
    input  logic                dsp_psel,
    input  qsnd_pkg::dsp_word_t dsp_serout,
    output qsnd_pkg::audio_t    left,
    output qsnd_pkg::audio_t    right,
    output logic                sample
);

    import qsnd_pkg::*;

    audio_t reg_left;
    audio_t reg_right;
    audio_t scaled;
    logic   last_sadd;
    logic   last_psel;
    logic   sadd_fall;
    logic   psel_rise;

    assign sadd_fall = ~dsp_sadd & last_sadd;
    assign psel_rise = dsp_psel & ~last_psel;
    assign scaled    = audio_t'(dsp_serout << `QSND_AUDIO_SHIFT);

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            last_sadd <= 1'b0;
            last_psel <= 1'b1; // no pair published straight out of reset
            reg_left  <= '0;
            reg_right <= '0;
            left      <= '0;
            right     <= '0;
            sample    <= 1'b0;
        end else begin
            last_sadd <= dsp_sadd;
            last_psel <= dsp_psel;
            if (sadd_fall) begin
                if (dsp_psel)
                    reg_right <= scaled;
                else
                    reg_left  <= scaled;
            end
            // psel going high closes the stereo frame
            if (psel_rise) begin
                left   <= reg_left;
                right  <= reg_right;
                sample <= 1'b1;
            end else begin
                sample <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/qsnd_sound_top.sv
/*
  top level of the host glue
  host registers feed the mailbox, the DSP pins feed the address and audio stages
  and the clock enable runs alongside
*/
`timescale 1ns/10ps
`default_nettype none

module qsnd_sound_top (
    input  logic                 clk48,
    input  logic                 rst,
    // host Wishbone port
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  qsnd_pkg::host_byte_t wb_dat_w,
    output qsnd_pkg::host_byte_t wb_dat_r,
    output logic                 wb_ack,
    output qsnd_pkg::bank_t      bank,
    // DSP control and parallel port
    output logic                 dsp_rst,
    output logic                 dsp_irq,
    output logic                 dsp_rdy_n,
    input  logic                 dsp_iack,
    input  logic                 dsp_pids_n,
    input  logic                 dsp_pods_n,
    output qsnd_pkg::dsp_word_t  dsp_pbus_in,
    input  qsnd_pkg::dsp_word_t  dsp_pbus_out,
    // sample ROM side
    input  logic                 dsp_cen_cko,
    input  qsnd_pkg::dsp_word_t  dsp_ab,
    input  logic                 dsp_ext_rq,
    input  logic                 qsnd_ok,
    output qsnd_pkg::qsnd_addr_t qsnd_addr,
    output logic                 cen_dsp,
    // audio
    input  logic                 dsp_sadd,
    input  logic                 dsp_psel,
    input  qsnd_pkg::dsp_word_t  dsp_serout,
    output qsnd_pkg::audio_t     left,
    output qsnd_pkg::audio_t     right,
    output logic                 sample
);

    import qsnd_pkg::*;

    dsp_word_t  mail_data;
    host_byte_t mail_addr;
    logic       mail_load;

    qsnd_host_regs u_host_regs (
        .clk48     (clk48),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .dsp_rdy_n (dsp_rdy_n),
        .bank      (bank),
        .dsp_rst   (dsp_rst),
        .mail_data (mail_data),
        .mail_addr (mail_addr),
        .mail_load (mail_load)
    );

    qsnd_mailbox u_mailbox (
        .clk48       (clk48),
        .rst         (rst),
        .mail_load   (mail_load),
        .mail_data   (mail_data),
        .mail_addr   (mail_addr),
        .dsp_pids_n  (dsp_pids_n),
        .dsp_iack    (dsp_iack),
        .dsp_irq     (dsp_irq),
        .dsp_rdy_n   (dsp_rdy_n),
        .dsp_pbus_in (dsp_pbus_in)
    );

    qsnd_dsp_cen u_dsp_cen (
        .clk48      (clk48),
        .rst        (rst),
        .qsnd_ok    (qsnd_ok),
        .dsp_ext_rq (dsp_ext_rq),
        .cen_dsp    (cen_dsp)
    );

    qsnd_rom_addr u_rom_addr (
        .clk48        (clk48),
        .rst          (rst),
        .dsp_pods_n   (dsp_pods_n),
        .dsp_cen_cko  (dsp_cen_cko),
        .dsp_pbus_out (dsp_pbus_out),
        .dsp_ab       (dsp_ab),
        .qsnd_addr    (qsnd_addr)
    );

    qsnd_audio_latch u_audio_latch (
        .clk48      (clk48),
        .rst        (rst),
        .dsp_sadd   (dsp_sadd),
        .dsp_psel   (dsp_psel),
        .dsp_serout (dsp_serout),
        .left       (left),
        .right      (right),
        .sample     (sample)
    );

endmodule

`default_nettype wire

// File: tb/qsnd_assertions.sv
/*
  concurrent checks on the host handshake, the sample strobe and the DSP reset
  bound into the top level
*/
`timescale 1ns/10ps
`default_nettype none

`include "qsnd_defines.svh"

module qsnd_assertions (
    input logic                 clk48,
    input logic                 rst,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_we,
    input logic [2:0]           wb_adr,
    input qsnd_pkg::host_byte_t wb_dat_w,
    input logic                 wb_ack,
    input logic                 dsp_rst,
    input logic                 sample
);

    int   fail_count = 0;
    logic run_q; // run bit as last written by the host

    always_ff @(posedge clk48, posedge rst) begin
        if (rst)
            run_q <= 1'b0;
        else if (wb_cyc && wb_stb && wb_we && !wb_ack && wb_adr == `QSND_REG_CTRL)
            run_q <= wb_dat_w[7];
    end

    ack_single: assert property (@(posedge clk48) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack high for two cycles");
        end

    sample_single: assert property (@(posedge clk48) disable iff (rst) sample |=> !sample)
        else begin
            fail_count++;
            $error("sample high for two cycles");
        end

    rst_follows_run: assert property (@(posedge clk48) disable iff (rst) dsp_rst == !run_q)
        else begin
            fail_count++;
            $error("dsp_rst does not follow the run bit");
        end

endmodule

bind qsnd_sound_top qsnd_assertions asrt_i (.*);

`default_nettype wire

// File: tb/qsnd_tb.sv
/*
  testbench for the sound board glue
  plays the host CPU and the DSP and checks the top level against a cycle model
*/
`timescale 1ns/10ps
`default_nettype none

`include "qsnd_defines.svh"

module qsnd_tb;

    import qsnd_pkg::*;

    logic       clk48;
    logic       rst;
    logic       wb_cyc, wb_stb, wb_we, wb_ack;
    logic [2:0] wb_adr;
    host_byte_t wb_dat_w, wb_dat_r;
    bank_t      bank;
    logic       dsp_rst, dsp_irq, dsp_rdy_n, dsp_iack, dsp_pids_n, dsp_pods_n;
    dsp_word_t  dsp_pbus_in, dsp_pbus_out, dsp_ab, dsp_serout;
    logic       dsp_cen_cko, dsp_ext_rq, qsnd_ok, cen_dsp;
    qsnd_addr_t qsnd_addr;
    logic       dsp_sadd, dsp_psel, sample;
    audio_t     left, right;

    integer     seed;
    // reference model state
    bank_t      m_bank;
    logic       m_irq;
    qsnd_addr_t m_addr;
    logic       m_pods_n, m_sadd, m_psel, m_sample;
    audio_t     m_lat_l, m_lat_r, m_left, m_right;

    qsnd_sound_top dut_i (.*);

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    always @(posedge clk48) begin
        if (dut_i.asrt_i.fail_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end
    end

    task automatic step;
        @(posedge clk48);
        #1; // outputs settled and inputs may change
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic give_up(input string what);
        $display("timed out waiting for %s", what);
        $display("=== FAIL ===");
        $fatal(1, "timeout on %s", what);
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input host_byte_t dat,
                             output host_byte_t rdata);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            step;
            n++;
        end while (!wb_ack && n < 20);
        if (!wb_ack)
            give_up("Wishbone ack");
        rdata  = wb_dat_r; // valid with ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (dsp_irq !== level && n < 20) begin
            step;
            n++;
        end
        if (dsp_irq !== level)
            give_up("dsp_irq to change");
    endtask

    task automatic read_status(input string name);
        host_byte_t rd;
        logic       rdy_n;
        rdy_n = ~(m_irq | dsp_iack);
        wb_access(1'b0, `QSND_REG_STATUS, 8'h00, rd);
        check(name, {rdy_n, 3'b111, m_bank}, rd);
        check("dsp_rdy_n pin", rdy_n, dsp_rdy_n);
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] w;
        host_byte_t  rd;
        host_byte_t  mb_addr;
        dsp_word_t   mb_data;
        int          cen_count;
        seed = 32'h6723_d398;
        rst = 1'b1;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
        {dsp_iack, dsp_cen_cko, dsp_ext_rq, dsp_sadd, dsp_psel} = '0;
        {dsp_pbus_out, dsp_ab, dsp_serout} = '0;
        dsp_pids_n = 1'b1;
        dsp_pods_n = 1'b1;
        qsnd_ok    = 1'b1;
        {m_bank, m_irq, m_addr, m_sadd, m_psel} = '0;
        {m_lat_l, m_lat_r, m_left, m_right} = '0;
        m_pods_n = 1'b1;
        repeat (5) @(posedge clk48);
        #1 rst = 1'b0;
        check("reset cen_dsp", 1, cen_dsp);
        check("reset dsp_rst", 1, dsp_rst);
        check("reset irq ack sample", 0, {dsp_irq, wb_ack, sample});
        check("reset qsnd_addr", 0, qsnd_addr);
        check("reset bank", 0, bank);

        // control writes with status and unmapped reads
        for (int i = 0; i < 16; i++) begin
            v = $random(seed);
            wb_access(1'b1, `QSND_REG_CTRL, v[7:0], rd);
            m_bank = v[3:0];
            check("ctrl dsp_rst", !v[7], dsp_rst);
            check("ctrl bank", m_bank, bank);
            read_status("status after ctrl");
            wb_access(1'b0, v[10:8] % 7, v[23:16], rd);
            check("unmapped read", 8'hff, rd);
        end

        // mailbox handoff with the address word first
        for (int i = 0; i < 8; i++) begin
            mb_data = $random(seed);
            mb_addr = $random(seed);
            wb_access(1'b1, `QSND_REG_DATA_HI, mb_data[15:8], rd);
            wb_access(1'b1, `QSND_REG_DATA_LO, mb_data[7:0], rd);
            wb_access(1'b1, `QSND_REG_ADDR, mb_addr, rd);
            m_irq = 1'b1;
            wait_irq(1'b1);
            check("mailbox address word", {8'h00, mb_addr}, dsp_pbus_in);
            read_status("status with irq");
            dsp_pids_n = 1'b0; // DSP reads the address word
            step;
            dsp_pids_n = 1'b1;
            m_irq = 1'b0;
            wait_irq(1'b0);
            check("mailbox data word", mb_data, dsp_pbus_in);
            dsp_iack = 1'b1;
            read_status("status with iack");
            dsp_iack = 1'b0;
            read_status("status idle");
        end

        // ROM address from DSP strobes
        for (int i = 0; i < 200; i++) begin
            v = $random(seed);
            w = $random(seed);
            dsp_pods_n   = v[0];
            dsp_cen_cko  = v[1];
            dsp_pbus_out = w[31:16];
            dsp_ab       = w[15:0];
            if (dsp_pods_n && !m_pods_n)
                m_addr[15:0] = dsp_pbus_out;
            if (dsp_cen_cko && dsp_ab[15])
                m_addr[22:16] = dsp_ab[6:0];
            m_pods_n = dsp_pods_n;
            step;
            check("qsnd_addr", m_addr, qsnd_addr);
        end
        dsp_cen_cko = 1'b0;

        // audio frames where the publish takes the latches from before this edge
        for (int i = 0; i < 300; i++) begin
            v = $random(seed);
            dsp_sadd   = v[0];
            dsp_psel   = v[1] & v[2];
            dsp_serout = v[31:16];
            m_sample   = dsp_psel && !m_psel;
            if (m_sample) begin
                m_left  = m_lat_l;
                m_right = m_lat_r;
            end
            if (!dsp_sadd && m_sadd) begin
                if (dsp_psel)
                    m_lat_r = {dsp_serout[13:0], 2'b00};
                else
                    m_lat_l = {dsp_serout[13:0], 2'b00};
            end
            m_sadd = dsp_sadd;
            m_psel = dsp_psel;
            step;
            check("sample strobe", m_sample, sample);
            check("left", m_left, left);
            check("right", m_right, right);
        end

        // 30 cycles of ROM stalls followed by 30 cycles to make up the lost slots
        cen_count  = 0;
        dsp_ext_rq = 1'b1;
        for (int i = 0; i < 60; i++) begin
            v = $random(seed);
            cen_count += cen_dsp;
            qsnd_ok = (i < 30) ? v[0] : 1'b1;
            step;
        end
        check("cen_dsp count", 60 / `QSND_CEN_PHASES, cen_count);

        if (dut_i.asrt_i.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", dut_i.asrt_i.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
verilog/qsnd_pkg.sv
verilog/qsnd_host_regs.sv
verilog/qsnd_mailbox.sv
verilog/qsnd_dsp_cen.sv
verilog/qsnd_rom_addr.sv
verilog/qsnd_audio_latch.sv
verilog/qsnd_sound_top.sv
tb/qsnd_assertions.sv
tb/qsnd_tb.sv
